// File: verilog/calc_pkg.sv
package calc_pkg;

    // Datapath widths
    localparam int DATA_W  = 16;                // Operand and result width
    localparam int DIGIT_W = 4;                 // Keypad bus width
    localparam int DIGIT_MAX = 9;               // Largest decimal digit

    // Operator keys, one-hot
    localparam int OPSEL_W = 3;
    localparam logic [OPSEL_W-1:0] OPSEL_ADD = 3'b001;
    localparam logic [OPSEL_W-1:0] OPSEL_SUB = 3'b010;
    localparam logic [OPSEL_W-1:0] OPSEL_MUL = 3'b100;

    // Multiplier timing
    localparam int MULT_CYCLES = 16;            // One iteration per multiplier bit
    localparam int MULT_CNT_W  = $clog2(MULT_CYCLES);

    // Latched operator
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } calc_op_t;

    // Controller states
    typedef enum logic [2:0] {
        GET_FIRST_NUM  = 3'd0,                  // Building operand a
        GET_SECOND_NUM = 3'd1,                  // Building operand b
        START_CALC     = 3'd2,                  // One cycle, fires unit start
        WAIT_CALC      = 3'd3,                  // Waiting for unit finish
        SHOW_RESULT    = 3'd4                   // Complete pulse, operands clear
    } calc_state_t;

    // Both operands as one bundle
    typedef struct packed {
        logic [DATA_W-1:0] a;                   // First operand
        logic [DATA_W-1:0] b;                   // Second operand
    } calc_operands_t;

endpackage

// File: verilog/operand_entry.sv
`timescale 1ns/1ps

module operand_entry (
    input  logic                          clk,
    input  logic                          nRST,
    input  logic [calc_pkg::DIGIT_W-1:0]  keypad_input,   // Single keypad digit
    input  logic                          read_input,     // Digit strobe
    input  logic                          entry_en,       // High in entry states
    input  logic                          entry_sel,      // 0 operand a, 1 operand b
    input  logic                          entry_clear,    // Zero both operands
    output calc_pkg::calc_operands_t      operands
);
    import calc_pkg::*;

    logic              digit_valid;                       // Keypad value 0 to 9
    logic              digit_load;                        // Accept this digit
    logic [DATA_W-1:0] cur_value;                         // Operand being built
    logic [DATA_W-1:0] next_value;                        // Value times ten plus digit

    assign digit_valid = (keypad_input <= DIGIT_W'(DIGIT_MAX));
    assign digit_load  = entry_en && read_input && digit_valid;

    // Pick the operand that the digit goes into
    assign cur_value = entry_sel ? operands.b : operands.a;

    // x*10 as x*8 + x*2, wraps at 16 bits
    assign next_value = (cur_value << 3) + (cur_value << 1)
                      + {{(DATA_W-DIGIT_W){1'b0}}, keypad_input};

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            operands <= '0;
        end else if (entry_clear) begin
            operands <= '0;                               // Clear after result shown
        end else if (digit_load) begin
            if (entry_sel) begin
                operands.b <= next_value;
            end else begin
                operands.a <= next_value;
            end
        end
    end

endmodule

// File: verilog/add_sub_unit.sv
`timescale 1ns/1ps

module add_sub_unit (
    input  logic                         clk,
    input  logic                         nRST,
    input  calc_pkg::calc_operands_t     operands,       // a and b from entry
    input  calc_pkg::calc_op_t           op,             // Latched operator
    input  logic                         start_add_sub,  // One-cycle start
    output logic [calc_pkg::DATA_W-1:0]  add_sub_result,
    output logic                         add_sub_finish  // Result valid pulse
);
    import calc_pkg::*;

    logic [DATA_W-1:0] sum;                              // a + b
    logic [DATA_W-1:0] diff;                             // a - b, two's complement

    assign sum  = operands.a + operands.b;
    assign diff = operands.a - operands.b;

    // Result register, loaded only on start
    always_ff @(posedge clk) begin
        if (start_add_sub) begin
            add_sub_result <= (op == OP_SUB) ? diff : sum;
        end
    end

    // Finish one cycle behind start
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            add_sub_finish <= 1'b0;
        end else begin
            add_sub_finish <= start_add_sub;
        end
    end

endmodule

// File: verilog/seq_multiplier.sv
`timescale 1ns/1ps

module seq_multiplier (
    input  logic                         clk,
    input  logic                         nRST,
    input  calc_pkg::calc_operands_t     operands,     // a times b
    input  logic                         start_mult,   // One-cycle start
    output logic [calc_pkg::DATA_W-1:0]  mult_result,  // Low 16 bits of product
    output logic                         mult_finish   // Product valid pulse
);
    import calc_pkg::*;

    logic                  busy;                       // Iterations in progress
    logic [MULT_CNT_W-1:0] count;                      // Iterations still to run
    logic [DATA_W-1:0]     mcand;                      // Shifted multiplicand
    logic [DATA_W-1:0]     mplier;                     // Shifted multiplier
    logic [DATA_W-1:0]     product;                    // Partial product
    logic                  step;                       // Iterate this cycle
    logic [DATA_W-1:0]     cur_mcand;
    logic [DATA_W-1:0]     cur_mplier;
    logic [DATA_W-1:0]     cur_product;
    logic [DATA_W-1:0]     step_sum;

    assign step = start_mult || busy;

    // First iteration runs straight off the operands at start
    assign cur_mcand   = start_mult ? operands.a : mcand;
    assign cur_mplier  = start_mult ? operands.b : mplier;
    assign cur_product = start_mult ? '0 : product;

    // Add multiplicand when current multiplier bit set
    assign step_sum = cur_product + (cur_mplier[0] ? cur_mcand : '0);

    // Datapath, no reset
    always_ff @(posedge clk) begin
        if (step) begin
            product <= step_sum;
            mcand   <= cur_mcand << 1;                 // Next bit weight
            mplier  <= cur_mplier >> 1;                // Next bit into LSB
        end
    end

    // Iteration control
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy        <= 1'b0;
            count       <= '0;
            mult_finish <= 1'b0;
        end else begin
            mult_finish <= 1'b0;
            if (start_mult) begin
                busy  <= 1'b1;
                count <= MULT_CNT_W'(MULT_CYCLES - 1); // One iteration done at start
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == MULT_CNT_W'(1)) begin
                    busy        <= 1'b0;               // Last iteration this edge
                    mult_finish <= 1'b1;
                end
            end
        end
    end

    assign mult_result = product;

endmodule

// File: verilog/calc_controller.sv
`timescale 1ns/1ps

module calc_controller (
    input  logic                         clk,
    input  logic                         nRST,
    input  logic [calc_pkg::OPSEL_W-1:0] operator_input,  // One-hot operator key
    input  logic                         equal_input,     // Equal strobe
    input  logic                         add_sub_finish,
    input  logic [calc_pkg::DATA_W-1:0]  add_sub_result,
    input  logic                         mult_finish,
    input  logic [calc_pkg::DATA_W-1:0]  mult_result,
    output logic                         entry_en,        // Digits accepted
    output logic                         entry_sel,       // 0 first, 1 second operand
    output logic                         entry_clear,     // Zero operands
    output calc_pkg::calc_op_t           op,              // Latched operator
    output logic                         start_add_sub,
    output logic                         start_mult,
    output logic                         complete,        // Result pulse
    output logic [calc_pkg::DATA_W-1:0]  display_output   // Held result
);
    import calc_pkg::*;

    calc_state_t       state;
    calc_state_t       next_state;
    logic              op_valid;                          // Operator key is one-hot
    calc_op_t          op_decoded;
    logic              unit_finish;                       // Finish of started unit
    logic [DATA_W-1:0] unit_result;                       // Result of started unit

    // One-hot operator decode, anything else ignored
    always_comb begin
        op_valid   = 1'b1;
        op_decoded = OP_ADD;
        case (operator_input)
            OPSEL_ADD: op_decoded = OP_ADD;
            OPSEL_SUB: op_decoded = OP_SUB;
            OPSEL_MUL: op_decoded = OP_MUL;
            default:   op_valid   = 1'b0;
        endcase
    end

    // Follow the unit that op selected
    assign unit_finish = (op == OP_MUL) ? mult_finish : add_sub_finish;
    assign unit_result = (op == OP_MUL) ? mult_result : add_sub_result;

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            GET_FIRST_NUM: begin
                if (op_valid) begin
                    next_state = GET_SECOND_NUM;
                end
            end
            GET_SECOND_NUM: begin
                if (equal_input) begin
                    next_state = START_CALC;
                end
            end
            START_CALC: next_state = WAIT_CALC;           // Single cycle
            WAIT_CALC: begin
                if (unit_finish) begin
                    next_state = SHOW_RESULT;
                end
            end
            SHOW_RESULT: next_state = GET_FIRST_NUM;
            default: next_state = GET_FIRST_NUM;
        endcase
    end

    // State, operator, result and complete registers
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= GET_FIRST_NUM;
            op             <= OP_ADD;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            state    <= next_state;
            complete <= 1'b0;
            if (state == GET_FIRST_NUM && op_valid) begin
                op <= op_decoded;                         // Latch on leaving first entry
            end
            if (state == WAIT_CALC && unit_finish) begin
                complete       <= 1'b1;                   // High during SHOW_RESULT
                display_output <= unit_result;            // Same edge as complete
            end
        end
    end

    // Decoded controls
    assign entry_en      = (state == GET_FIRST_NUM) || (state == GET_SECOND_NUM);
    assign entry_sel     = (state == GET_SECOND_NUM);
    assign entry_clear   = (state == SHOW_RESULT);
    assign start_add_sub = (state == START_CALC) && (op != OP_MUL);
    assign start_mult    = (state == START_CALC) && (op == OP_MUL);

endmodule

// File: verilog/calc_top.sv
`timescale 1ns/1ps

module calc_top (
    input  logic                         clk,
    input  logic                         nRST,
    input  logic [calc_pkg::DIGIT_W-1:0] keypad_input,    // Decimal digit
    input  logic                         read_input,      // Digit strobe
    input  logic [calc_pkg::OPSEL_W-1:0] operator_input,  // 001 add, 010 sub, 100 mul
    input  logic                         equal_input,     // Start calculation
    output logic                         complete,        // Result pulse
    output logic [calc_pkg::DATA_W-1:0]  display_output   // Last result
);
    import calc_pkg::*;

    calc_operands_t    operands;                          // a and b
    logic              entry_en;
    logic              entry_sel;
    logic              entry_clear;
    calc_op_t          op;
    logic              start_add_sub;
    logic              start_mult;
    logic [DATA_W-1:0] add_sub_result;
    logic              add_sub_finish;
    logic [DATA_W-1:0] mult_result;
    logic              mult_finish;

    operand_entry u_entry (
        .clk          (clk),
        .nRST         (nRST),
        .keypad_input (keypad_input),
        .read_input   (read_input),
        .entry_en     (entry_en),
        .entry_sel    (entry_sel),
        .entry_clear  (entry_clear),
        .operands     (operands)
    );

    calc_controller u_ctrl (
        .clk            (clk),
        .nRST           (nRST),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .add_sub_finish (add_sub_finish),
        .add_sub_result (add_sub_result),
        .mult_finish    (mult_finish),
        .mult_result    (mult_result),
        .entry_en       (entry_en),
        .entry_sel      (entry_sel),
        .entry_clear    (entry_clear),
        .op             (op),
        .start_add_sub  (start_add_sub),
        .start_mult     (start_mult),
        .complete       (complete),
        .display_output (display_output)
    );

    add_sub_unit u_add_sub (
        .clk            (clk),
        .nRST           (nRST),
        .operands       (operands),
        .op             (op),
        .start_add_sub  (start_add_sub),
        .add_sub_result (add_sub_result),
        .add_sub_finish (add_sub_finish)
    );

    seq_multiplier u_mult (
        .clk         (clk),
        .nRST        (nRST),
        .operands    (operands),
        .start_mult  (start_mult),
        .mult_result (mult_result),
        .mult_finish (mult_finish)
    );

endmodule

// File: testbench/calc_checker.sv
`timescale 1ns/1ps

module calc_checker (
    input logic                  clk,
    input logic                  nRST,
    input logic                  complete,
    input logic                  start_add_sub,
    input logic                  add_sub_finish,
    input logic                  start_mult,
    input logic                  mult_finish,
    input logic                  mult_busy,      // Multiplier iterating
    input calc_pkg::calc_state_t state           // Controller state
);
    import calc_pkg::*;

    // Single-cycle complete
    a_complete_pulse: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete) else $error("complete high two cycles in a row");

    // Units answer only while the controller waits
    a_finish_state: assert property (@(posedge clk) disable iff (!nRST)
        (add_sub_finish || mult_finish) |-> state == WAIT_CALC)
        else $error("unit finish outside WAIT_CALC");

    // Add/sub answers exactly one cycle after start
    a_add_sub_lat: assert property (@(posedge clk) disable iff (!nRST)
        start_add_sub |=> add_sub_finish) else $error("add_sub_finish missing after start");
    a_add_sub_src: assert property (@(posedge clk) disable iff (!nRST)
        add_sub_finish |-> $past(start_add_sub)) else $error("add_sub_finish without start");

    // Multiplier latency fixed at MULT_CYCLES
    a_mult_lat: assert property (@(posedge clk) disable iff (!nRST)
        start_mult |-> ##MULT_CYCLES mult_finish) else $error("mult_finish late or missing");
    a_mult_src: assert property (@(posedge clk) disable iff (!nRST)
        mult_finish |-> $past(start_mult, MULT_CYCLES)) else $error("mult_finish unexpected");
    a_mult_busy: assert property (@(posedge clk) disable iff (!nRST)
        start_mult |-> !mult_busy) else $error("start_mult while multiplier busy");

    a_reset_quiet: assert property (@(posedge clk)
        !nRST |-> !complete) else $error("complete high during reset");

endmodule

bind calc_top calc_checker u_checker (
    .clk            (clk),
    .nRST           (nRST),
    .complete       (complete),
    .start_add_sub  (start_add_sub),
    .add_sub_finish (add_sub_finish),
    .start_mult     (start_mult),
    .mult_finish    (mult_finish),
    .mult_busy      (u_mult.busy),
    .state          (u_ctrl.state)
);

// File: testbench/calc_tb.sv
`timescale 1ns/1ps

module calc_tb;
    import calc_pkg::*;

    localparam logic [31:0] SEED = 32'hade007ae;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY  = 2;                  // Inputs change after the edge
    localparam int CALC_TIMEOUT = 100;                // Cycles allowed per result
    localparam int NUM_RANDOM   = 20;

    logic               clk;
    logic               nRST;
    logic [DIGIT_W-1:0] keypad_input;
    logic               read_input;
    logic [OPSEL_W-1:0] operator_input;
    logic               equal_input;
    logic               complete;
    logic [DATA_W-1:0]  display_output;

    logic [31:0]        lcg_state;
    logic [DATA_W-1:0]  exp_result;                   // Expected value of next result
    logic               exp_pending;                  // A result is due
    int                 err_count;
    int                 check_count;
    int                 test_count;
    int                 test_errs;                    // Error count when test began

    calc_top DUT (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw(input int unsigned range, output int unsigned r);
        lcg_state = lcg_next(lcg_state);
        r = lcg_state[31:8] % range;                  // Upper bits are better mixed
    endtask

    // Decimal operands mod 2^16, one-hot operator
    function automatic logic [DATA_W-1:0] calc_ref(input int unsigned a, input int unsigned b,
                                                   input logic [2:0] opsel);
        logic [15:0] a16;
        logic [15:0] b16;
        logic [31:0] prod;
        a16 = 16'(a % 32'd65536);
        b16 = 16'(b % 32'd65536);
        prod = a16 * b16;
        case (opsel)
            3'b001:  return a16 + b16;
            3'b010:  return a16 - b16;
            default: return prod[15:0];
        endcase
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // One read strobe per digit, junk keys 10..15 in between when noisy
    task automatic enter_number(input int unsigned value, input bit noisy);
        int unsigned digits[$];
        int unsigned v;
        v = value;
        do begin
            digits.push_front(v % 10);
            v = v / 10;
        end while (v != 0);
        foreach (digits[i]) begin
            if (noisy) begin
                for (int k = 10; k <= 15; k++) begin
                    keypad_input = 4'(k);             // Not a digit
                    read_input   = 1'b1;
                    next_cycle();
                end
            end
            keypad_input = 4'(digits[i]);
            read_input   = 1'b1;
            next_cycle();
        end
        read_input   = 1'b0;
        keypad_input = '0;
    endtask

    task automatic press_operator(input logic [OPSEL_W-1:0] opsel);
        operator_input = opsel;
        next_cycle();
        operator_input = '0;
    endtask

    task automatic press_equal();
        equal_input = 1'b1;
        next_cycle();
        equal_input = 1'b0;
    endtask

    task automatic run_calc(input int unsigned a, input int unsigned b,
                            input logic [OPSEL_W-1:0] opsel, input bit noisy);
        int cycles;
        if (noisy) begin
            press_equal();                            // No operator yet, ignored
        end
        enter_number(a, noisy);
        if (noisy) begin
            press_operator(3'b011);                   // Not one-hot
            press_operator(3'b111);
        end
        press_operator(opsel);
        enter_number(b, noisy);
        exp_result  = calc_ref(a, b, opsel);
        exp_pending = 1'b1;
        press_equal();
        cycles = 0;
        while (!complete && cycles < CALC_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (!complete) begin
            err_count++;
            exp_pending = 1'b0;
            $display("Error: no complete within %0d cycles for %0d and %0d", CALC_TIMEOUT, a, b);
        end
        next_cycle();                                 // Back in GET_FIRST_NUM
        check_equal("display_output", display_output, exp_result);  // Held after complete
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("Test %0d %s: %0d errors", test_count, name, err_count - test_errs);
        test_errs = err_count;
    endtask

    // Compare on every complete, sampled mid-cycle
    always @(negedge clk) begin
        if (nRST && complete) begin
            if (exp_pending) begin
                check_equal("display_output", display_output, exp_result);
                exp_pending = 1'b0;
            end else begin
                err_count++;
                $display("Error: complete pulsed with no calculation pending at %0t", $time);
            end
        end
    end

    initial begin
        int unsigned a;
        int unsigned b;
        int unsigned ndig;
        int unsigned opidx;
        int unsigned lim;
        clk            = 1'b0;
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
        lcg_state      = SEED;
        exp_result     = '0;
        exp_pending    = 1'b0;
        err_count      = 0;
        check_count    = 0;
        test_count     = 0;
        test_errs      = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        nRST = 1'b1;
        next_cycle();
        check_equal("display_output", display_output, 0);

        run_calc(123, 4567, 3'b001, 0);
        run_calc(65535, 2, 3'b001, 0);                // Wraps to 1
        finish_test("addition");

        run_calc(5, 12, 3'b010, 0);
        run_calc(4096, 96, 3'b010, 0);
        finish_test("subtraction");

        run_calc(250, 300, 3'b100, 0);
        run_calc(0, 1234, 3'b100, 0);
        run_calc(777, 0, 3'b100, 0);
        finish_test("multiplication");

        run_calc(42, 17, 3'b010, 1);
        run_calc(305, 21, 3'b100, 1);
        finish_test("ignored inputs");

        repeat (NUM_RANDOM) begin
            draw(5, ndig);
            lim = 10;
            repeat (ndig) lim = lim * 10;             // Up to five digits
            draw(lim, a);
            draw(5, ndig);
            lim = 10;
            repeat (ndig) lim = lim * 10;
            draw(lim, b);
            draw(3, opidx);
            run_calc(a, b, 3'(3'b001 << opidx), 0);
        end
        finish_test("random calculations");

        enter_number(1234, 0);
        press_operator(3'b100);
        enter_number(56, 0);
        press_equal();
        repeat (6) next_cycle();                      // Multiplier mid-run
        nRST = 1'b0;
        repeat (3) next_cycle();
        check_equal("complete", complete, 0);
        check_equal("display_output", display_output, 0);
        nRST = 1'b1;
        repeat (MULT_CYCLES + 4) begin
            next_cycle();
            check_equal("complete", complete, 0);
        end
        check_equal("display_output", display_output, 0);
        run_calc(31, 69, 3'b001, 0);
        finish_test("reset mid-calculation");

        $display("Tests: %0d  Checks: %0d  Errors: %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
verilog/calc_pkg.sv
verilog/operand_entry.sv
verilog/add_sub_unit.sv
verilog/seq_multiplier.sv
verilog/calc_controller.sv
verilog/calc_top.sv
testbench/calc_checker.sv
testbench/calc_tb.sv
